//--- alloc_pkg.sv
package alloc_pkg;

    // -------------------------------------------------------------------------
    // Sizes
    // -------------------------------------------------------------------------
    localparam int PTR_WID = 4;
    localparam int NUM_BUFFERS = 2 ** PTR_WID;

    // Bytes held by one buffer
    localparam int BUFFER_SIZE = 64;
    localparam int BUF_LEN_WID = $clog2(BUFFER_SIZE + 1);

    // Frames longer than this are flagged as errors
    localparam int MAX_FRAME_SIZE = 256;
    localparam int FRAME_SIZE_WID = $clog2(MAX_FRAME_SIZE + 1);

    localparam int META_WID = 8;

    // -------------------------------------------------------------------------
    // Types
    // -------------------------------------------------------------------------
    typedef logic [PTR_WID-1:0] ptr_t;
    typedef logic [BUF_LEN_WID-1:0] buf_len_t;
    typedef logic [FRAME_SIZE_WID-1:0] frame_size_t;
    typedef logic [META_WID-1:0] meta_t;

    // Link descriptor, one per buffer
    typedef struct packed {
        ptr_t     next_ptr;
        buf_len_t len;
        logic     eof;
    } desc_t;

endpackage : alloc_pkg

//--- alloc_bv.sv
`timescale 1ns/10ps

module alloc_bv (
    input  logic                      clk,
    input  logic                      rst,

    // Allocation limit where 0 means all buffers
    input  logic [alloc_pkg::PTR_WID:0] buffers,

    input  logic                      alloc_req,
    output logic                      alloc_rdy,
    output alloc_pkg::ptr_t           alloc_ptr,

    input  logic                      dealloc_req,
    input  alloc_pkg::ptr_t           dealloc_ptr,

    input  logic                      recycle_req,
    output logic                      recycle_rdy,
    input  alloc_pkg::ptr_t           recycle_ptr
);

    typedef logic [alloc_pkg::PTR_WID:0] cnt_t;

    logic [alloc_pkg::NUM_BUFFERS-1:0] used;
    cnt_t                              alloc_cnt;
    cnt_t                              limit;
    logic                              init_done;
    logic                              free_found;
    logic                              take;
    logic                              recycle_fire;

    // -------------------------------------------------------------------------
    // Lowest free pointer
    // -------------------------------------------------------------------------
    // Scan downwards so the lowest free index is the last one kept
    always_comb begin
        free_found = 1'b0;
        alloc_ptr = '0;
        for (int i = alloc_pkg::NUM_BUFFERS - 1; i >= 0; i--) begin
            if (!used[i]) begin
                free_found = 1'b1;
                alloc_ptr = alloc_pkg::ptr_t'(i);
            end
        end
    end

    assign limit = (buffers == '0) ? cnt_t'(alloc_pkg::NUM_BUFFERS) : buffers;

    assign alloc_rdy = init_done && free_found && (alloc_cnt < limit);
    assign take = alloc_req && alloc_rdy;

    // Gather frees win and recycle uses the slot otherwise
    assign recycle_rdy = init_done && !dealloc_req;
    assign recycle_fire = recycle_req && recycle_rdy;

    // -------------------------------------------------------------------------
    // Used vector and count
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            used <= '0;
            alloc_cnt <= '0;
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b1;
            if (take) begin
                used[alloc_ptr] <= 1'b1;
            end
            if (dealloc_req) begin
                used[dealloc_ptr] <= 1'b0;
            end
            if (recycle_fire) begin
                used[recycle_ptr] <= 1'b0;
            end
            alloc_cnt <= alloc_cnt + cnt_t'(take) - cnt_t'(dealloc_req)
                       - cnt_t'(recycle_fire);
        end
    end

    // -------------------------------------------------------------------------
    // Checks
    // -------------------------------------------------------------------------
    // Gather and recycle only return pointers handed out earlier
    a_dealloc_in_use: assert property (
        @(posedge clk) disable iff (rst) dealloc_req |-> used[dealloc_ptr]
    );

    a_recycle_in_use: assert property (
        @(posedge clk) disable iff (rst) recycle_fire |-> used[recycle_ptr]
    );

    // Buffers actually in use stay below the limit at every take
    a_take_limit: assert property (
        @(posedge clk) disable iff (rst) take |-> ($countones(used) < limit)
    );

endmodule : alloc_bv

//--- desc_ram.sv
`timescale 1ns/10ps

module desc_ram #(
    parameter type data_t = alloc_pkg::desc_t
) (
    input  logic            clk,

    // Write port
    input  logic            wr_en,
    input  alloc_pkg::ptr_t wr_addr,
    input  data_t           wr_data,

    // Read port, data one cycle after rd_en
    input  logic            rd_en,
    input  alloc_pkg::ptr_t rd_addr,
    output data_t           rd_data
);

    // -------------------------------------------------------------------------
    // Storage, one entry per buffer
    // -------------------------------------------------------------------------
    data_t mem [alloc_pkg::NUM_BUFFERS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Same-cycle read returns the old entry
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule : desc_ram

//--- alloc_scatter.sv
`timescale 1ns/10ps

module alloc_scatter (
    input  logic                   clk,
    input  logic                   rst,

    // Store port
    input  logic                   store_req,
    input  alloc_pkg::buf_len_t    store_len,
    input  logic                   store_eof,
    input  alloc_pkg::meta_t       store_meta,
    output logic                   store_rdy,
    output alloc_pkg::ptr_t        store_ptr,

    // Allocator
    output logic                   alloc_req,
    input  logic                   alloc_rdy,
    input  alloc_pkg::ptr_t        alloc_ptr,

    // Link RAM write port
    output logic                   link_wr_en,
    output alloc_pkg::ptr_t        link_wr_addr,
    output alloc_pkg::desc_t       link_wr_data,

    // Meta RAM write port
    output logic                   meta_wr_en,
    output alloc_pkg::ptr_t        meta_wr_addr,
    output alloc_pkg::meta_t       meta_wr_data,

    // Frame completion
    output logic                   frame_valid,
    output logic                   frame_error,
    output alloc_pkg::ptr_t        frame_ptr,
    output alloc_pkg::frame_size_t frame_size
);

    typedef logic [alloc_pkg::FRAME_SIZE_WID:0] sum_t;

    alloc_pkg::ptr_t       cur_ptr;
    alloc_pkg::ptr_t       nxt_ptr;
    alloc_pkg::ptr_t       head_ptr;
    logic                  cur_vld;
    logic                  nxt_vld;
    alloc_pkg::frame_size_t byte_cnt;
    logic                  ovf;
    logic                  store_fire;
    logic                  eof_fire;
    logic                  take;
    sum_t                  sum;
    logic                  sum_ovf;

    // -------------------------------------------------------------------------
    // Handshake
    // -------------------------------------------------------------------------
    // Each transfer needs a refill pointer, so allocator stall blocks stores
    assign store_rdy = cur_vld && nxt_vld && alloc_rdy;
    assign store_ptr = cur_ptr;
    assign store_fire = store_req && store_rdy;
    assign eof_fire = store_fire && store_eof;

    assign alloc_req = !cur_vld || !nxt_vld || store_fire;
    assign take = alloc_req && alloc_rdy;

    // -------------------------------------------------------------------------
    // Pointer prefetch
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_vld <= 1'b0;
            nxt_vld <= 1'b0;
        end else if (take && !cur_vld) begin
            cur_vld <= 1'b1;
        end else if (take && !nxt_vld) begin
            nxt_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (store_fire) begin
            cur_ptr <= nxt_ptr;
            nxt_ptr <= alloc_ptr;
        end else if (take && !cur_vld) begin
            cur_ptr <= alloc_ptr;
        end else if (take && !nxt_vld) begin
            nxt_ptr <= alloc_ptr;
        end
    end

    // Head follows the link of the last buffer of each frame
    always_ff @(posedge clk) begin
        if (take && !cur_vld) begin
            head_ptr <= alloc_ptr;
        end else if (eof_fire) begin
            head_ptr <= nxt_ptr;
        end
    end

    // -------------------------------------------------------------------------
    // Descriptor writes
    // -------------------------------------------------------------------------
    assign link_wr_en = store_fire;
    assign link_wr_addr = cur_ptr;

    always_comb begin
        link_wr_data.next_ptr = nxt_ptr;
        link_wr_data.len = store_len;
        link_wr_data.eof = store_eof;
    end

    assign meta_wr_en = eof_fire;
    assign meta_wr_addr = head_ptr;
    assign meta_wr_data = store_meta;

    // -------------------------------------------------------------------------
    // Frame size and completion
    // -------------------------------------------------------------------------
    assign sum = {1'b0, byte_cnt} + sum_t'(store_len);
    assign sum_ovf = ovf || (sum > sum_t'(alloc_pkg::MAX_FRAME_SIZE));

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt <= '0;
            ovf <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= eof_fire;
            if (eof_fire) begin
                byte_cnt <= '0;
                ovf <= 1'b0;
            end else if (store_fire) begin
                byte_cnt <= sum[alloc_pkg::FRAME_SIZE_WID-1:0];
                ovf <= sum_ovf;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (eof_fire) begin
            frame_error <= sum_ovf;
            frame_ptr <= head_ptr;
            frame_size <= sum[alloc_pkg::FRAME_SIZE_WID-1:0];
        end
    end

    // Producer must fill each buffer with 1 to BUFFER_SIZE bytes
    a_store_len: assert property (
        @(posedge clk) disable iff (rst)
        store_fire |-> (store_len != '0) && (store_len <= alloc_pkg::BUFFER_SIZE)
    );

endmodule : alloc_scatter

//--- alloc_gather.sv
`timescale 1ns/10ps

module alloc_gather (
    input  logic                clk,
    input  logic                rst,

    // Load request
    input  logic                load_req,
    input  alloc_pkg::ptr_t     load_ptr,
    output logic                load_rdy,

    // Load result
    output logic                load_valid,
    output alloc_pkg::buf_len_t load_len,
    output logic                load_eof,
    output alloc_pkg::ptr_t     load_next,
    output alloc_pkg::meta_t    load_meta,

    // Shared read port of both RAMs
    output logic                rd_en,
    output alloc_pkg::ptr_t     rd_addr,
    input  alloc_pkg::desc_t    link_rd_data,
    input  alloc_pkg::meta_t    meta_rd_data,

    // Free loaded buffer
    output logic                dealloc_req,
    output alloc_pkg::ptr_t     dealloc_ptr
);

    logic            rdy_en;
    logic            accept;
    logic            s1_vld;
    alloc_pkg::ptr_t s1_ptr;
    alloc_pkg::ptr_t out_ptr;

    // -------------------------------------------------------------------------
    // Request accept with one load in flight
    // -------------------------------------------------------------------------
    assign load_rdy = rdy_en && !s1_vld && !load_valid;
    assign accept = load_req && load_rdy;

    assign rd_en = accept;
    assign rd_addr = load_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_en <= 1'b0;
            s1_vld <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            rdy_en <= 1'b1;
            s1_vld <= accept;
            load_valid <= s1_vld;
        end
    end

    // -------------------------------------------------------------------------
    // Result registers
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_ptr <= load_ptr;
        end
    end

    // RAM data is valid in the stage after the read
    always_ff @(posedge clk) begin
        if (s1_vld) begin
            load_len <= link_rd_data.len;
            load_eof <= link_rd_data.eof;
            load_next <= link_rd_data.next_ptr;
            load_meta <= meta_rd_data;
            out_ptr <= s1_ptr;
        end
    end

    // Buffer goes back to the pool as its result is presented
    assign dealloc_req = load_valid;
    assign dealloc_ptr = out_ptr;

    // Each result frees the pointer accepted two cycles earlier
    a_valid_after_accept: assert property (
        @(posedge clk) disable iff (rst)
        load_valid |-> $past(accept, 2) && (dealloc_ptr == $past(load_ptr, 2))
    );

endmodule : alloc_gather

//--- alloc_sg_core.sv
`timescale 1ns/10ps

module alloc_sg_core (
    input  logic                        clk,
    input  logic                        rst,

    // Allocation limit, 0 means all buffers
    input  logic [alloc_pkg::PTR_WID:0] buffers,

    // Store port
    input  logic                        store_req,
    input  alloc_pkg::buf_len_t         store_len,
    input  logic                        store_eof,
    input  alloc_pkg::meta_t            store_meta,
    output logic                        store_rdy,
    output alloc_pkg::ptr_t             store_ptr,

    // Frame completion
    output logic                        frame_valid,
    output logic                        frame_error,
    output alloc_pkg::ptr_t             frame_ptr,
    output alloc_pkg::frame_size_t      frame_size,

    // Load port
    input  logic                        load_req,
    input  alloc_pkg::ptr_t             load_ptr,
    output logic                        load_rdy,
    output logic                        load_valid,
    output alloc_pkg::buf_len_t         load_len,
    output logic                        load_eof,
    output alloc_pkg::ptr_t             load_next,
    output alloc_pkg::meta_t            load_meta,

    // Recycle port
    input  logic                        recycle_req,
    input  alloc_pkg::ptr_t             recycle_ptr,
    output logic                        recycle_rdy
);

    // -------------------------------------------------------------------------
    // Signals
    // -------------------------------------------------------------------------
    logic             alloc_req;
    logic             alloc_rdy;
    alloc_pkg::ptr_t  alloc_ptr;

    logic             dealloc_req;
    alloc_pkg::ptr_t  dealloc_ptr;

    logic             link_wr_en;
    alloc_pkg::ptr_t  link_wr_addr;
    alloc_pkg::desc_t link_wr_data;
    logic             meta_wr_en;
    alloc_pkg::ptr_t  meta_wr_addr;
    alloc_pkg::meta_t meta_wr_data;

    logic             rd_en;
    alloc_pkg::ptr_t  rd_addr;
    alloc_pkg::desc_t link_rd_data;
    alloc_pkg::meta_t meta_rd_data;

    // -------------------------------------------------------------------------
    // Pointer allocator
    // -------------------------------------------------------------------------
    alloc_bv u_alloc_bv (
        .clk,
        .rst,
        .buffers,
        .alloc_req,
        .alloc_rdy,
        .alloc_ptr,
        .dealloc_req,
        .dealloc_ptr,
        .recycle_req,
        .recycle_rdy,
        .recycle_ptr
    );

    // -------------------------------------------------------------------------
    // Descriptor store
    // -------------------------------------------------------------------------
    desc_ram #(
        .data_t  ( alloc_pkg::desc_t )
    ) u_link_ram (
        .clk,
        .wr_en   ( link_wr_en ),
        .wr_addr ( link_wr_addr ),
        .wr_data ( link_wr_data ),
        .rd_en,
        .rd_addr,
        .rd_data ( link_rd_data )
    );

    // Frame metadata, written at the head pointer only
    desc_ram #(
        .data_t  ( alloc_pkg::meta_t )
    ) u_meta_ram (
        .clk,
        .wr_en   ( meta_wr_en ),
        .wr_addr ( meta_wr_addr ),
        .wr_data ( meta_wr_data ),
        .rd_en,
        .rd_addr,
        .rd_data ( meta_rd_data )
    );

    // -------------------------------------------------------------------------
    // Scatter and gather
    // -------------------------------------------------------------------------
    alloc_scatter u_alloc_scatter (
        .clk,
        .rst,
        .store_req,
        .store_len,
        .store_eof,
        .store_meta,
        .store_rdy,
        .store_ptr,
        .alloc_req,
        .alloc_rdy,
        .alloc_ptr,
        .link_wr_en,
        .link_wr_addr,
        .link_wr_data,
        .meta_wr_en,
        .meta_wr_addr,
        .meta_wr_data,
        .frame_valid,
        .frame_error,
        .frame_ptr,
        .frame_size
    );

    alloc_gather u_alloc_gather (
        .clk,
        .rst,
        .load_req,
        .load_ptr,
        .load_rdy,
        .load_valid,
        .load_len,
        .load_eof,
        .load_next,
        .load_meta,
        .rd_en,
        .rd_addr,
        .link_rd_data,
        .meta_rd_data,
        .dealloc_req,
        .dealloc_ptr
    );

endmodule : alloc_sg_core

//--- tb_alloc_sg_core.sv
`timescale 1ns/10ps

module tb_alloc_sg_core;

    localparam int CLK_PERIOD = 100;
    localparam int RDY_WAIT = 20;
    localparam int STALL_WAIT = 6;
    localparam int CYCLES_PER_OP = 40;

    logic                        clk;
    logic                        rst;
    logic [alloc_pkg::PTR_WID:0] buffers;
    logic                        store_req;
    alloc_pkg::buf_len_t         store_len;
    logic                        store_eof;
    alloc_pkg::meta_t            store_meta;
    logic                        store_rdy;
    alloc_pkg::ptr_t             store_ptr;
    logic                        frame_valid;
    logic                        frame_error;
    alloc_pkg::ptr_t             frame_ptr;
    alloc_pkg::frame_size_t      frame_size;
    logic                        load_req;
    alloc_pkg::ptr_t             load_ptr;
    logic                        load_rdy;
    logic                        load_valid;
    alloc_pkg::buf_len_t         load_len;
    logic                        load_eof;
    alloc_pkg::ptr_t             load_next;
    alloc_pkg::meta_t            load_meta;
    logic                        recycle_req;
    alloc_pkg::ptr_t             recycle_ptr;
    logic                        recycle_rdy;

    // Op codes and their fields from the pattern file in order
    int   ops[$];
    int   args[$];
    int   op_total;
    bit   ops_ready;

    // Frames stored and not yet loaded back
    int   frame_heads[$];
    int   frame_metas[$];
    int   frame_counts[$];
    int   frame_lens[$];

    int   seed;
    int   errors;
    int   test_errors;
    int   tests_passed;
    int   tests_failed;
    logic last_error;

    alloc_sg_core u_alloc_sg_core (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // -------------------------------------------------------------------------
    // Reporting
    // -------------------------------------------------------------------------
    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
        test_errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s at %0t", msg, $time);
        test_errors++;
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", tests_passed + tests_failed, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d error(s)", tests_passed + tests_failed, name,
                     test_errors);
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    // -------------------------------------------------------------------------
    // Pattern reader
    // -------------------------------------------------------------------------
    task automatic read_patterns();
        int fd;
        int c;
        int rc;
        int val;
        int count;
        fd = $fopen("alloc_sg_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open pattern file alloc_sg_patterns.txt");
            errors++;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                case (c)
                    "#": begin
                        while (c != 10 && c != -1) begin
                            c = $fgetc(fd);
                        end
                    end
                    "L", "E": begin
                        rc = $fscanf(fd, "%d", val);
                        ops.push_back(c);
                        args.push_back(val);
                    end
                    "S": begin
                        rc = $fscanf(fd, "%d %d", val, count);
                        ops.push_back(c);
                        args.push_back(val);
                        args.push_back(count);
                    end
                    "F": begin
                        rc = $fscanf(fd, "%h %d", val, count);
                        ops.push_back(c);
                        args.push_back(val);
                        args.push_back(count);
                        for (int i = 0; i < count; i++) begin
                            rc = $fscanf(fd, "%d", val);
                            args.push_back(val);
                        end
                    end
                    "G": ops.push_back(c);
                    // Whitespace between fields
                    9, 10, 13, 32: ;
                    default: begin
                        $display("Unknown op code 0x%0h in pattern file", c);
                        errors++;
                    end
                endcase
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
        op_total = ops.size();
    endtask

    // -------------------------------------------------------------------------
    // Port drivers
    // -------------------------------------------------------------------------
    task automatic idle_gap();
        int gap;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) @(negedge clk);
    endtask

    // Wait for store_rdy and then make one buffer transfer
    task automatic store_buffer(input int len, input bit eof, input int meta,
                                input int max_wait, output bit done, output int ptr);
        int waited;
        waited = 0;
        while (!store_rdy && waited < max_wait) begin
            @(negedge clk);
            waited++;
        end
        done = store_rdy;
        ptr = store_ptr;
        if (done) begin
            store_req = 1'b1;
            store_len = alloc_pkg::buf_len_t'(len);
            store_eof = eof;
            store_meta = alloc_pkg::meta_t'(meta);
            @(negedge clk);
            store_req = 1'b0;
            store_eof = 1'b0;
        end
    endtask

    task automatic load_buffer(input int ptr, output bit done);
        int waited;
        waited = 0;
        while (!load_rdy && waited < RDY_WAIT) begin
            @(negedge clk);
            waited++;
        end
        done = load_rdy;
        if (!done) begin
            report_error("load_rdy stayed low");
        end else begin
            load_req = 1'b1;
            load_ptr = alloc_pkg::ptr_t'(ptr);
            @(negedge clk);
            load_req = 1'b0;
            if (load_valid !== 1'b0) report_error("load_valid one cycle after accept");
            @(negedge clk);
            if (load_valid !== 1'b1) begin
                report_error("load_valid missing two cycles after accept");
                done = 1'b0;
            end
        end
    endtask

    task automatic recycle_buffer(input int ptr);
        int waited;
        waited = 0;
        while (!recycle_rdy && waited < RDY_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!recycle_rdy) begin
            report_error("recycle_rdy stayed low");
        end else begin
            recycle_req = 1'b1;
            recycle_ptr = alloc_pkg::ptr_t'(ptr);
            @(negedge clk);
            recycle_req = 1'b0;
        end
    endtask

    // Called on the falling edge right after the end-of-frame transfer
    task automatic check_frame_done(input int head, input int sum);
        if (frame_valid !== 1'b1) begin
            report_error("frame_valid missing one cycle after end of frame");
        end else begin
            if (frame_ptr !== alloc_pkg::ptr_t'(head)) begin
                report_mismatch("frame_ptr", frame_ptr, head);
            end
            if (frame_size !== alloc_pkg::frame_size_t'(sum)) begin
                report_mismatch("frame_size", frame_size, sum);
            end
        end
        last_error = frame_error;
        @(negedge clk);
        if (frame_valid !== 1'b0) report_error("frame_valid held longer than one cycle");
    endtask

    // -------------------------------------------------------------------------
    // Tests
    // -------------------------------------------------------------------------
    task automatic check_reset();
        int waited;
        repeat (4) begin
            @(negedge clk);
            if (frame_valid !== 1'b0 || load_valid !== 1'b0 || store_rdy !== 1'b0) begin
                report_error("outputs not idle during reset");
            end
        end
        rst = 1'b0;
        @(negedge clk);
        if (store_rdy !== 1'b0) report_mismatch("store_rdy", store_rdy, 0);
        if (frame_valid !== 1'b0) report_mismatch("frame_valid", frame_valid, 0);
        if (load_valid !== 1'b0) report_mismatch("load_valid", load_valid, 0);
        if (load_rdy !== 1'b1) report_mismatch("load_rdy", load_rdy, 1);
        if (recycle_rdy !== 1'b1) report_mismatch("recycle_rdy", recycle_rdy, 1);
        waited = 0;
        while (!store_rdy && waited < RDY_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!store_rdy) report_error("store_rdy did not rise after reset");
    endtask

    task automatic run_frame();
        int meta;
        int count;
        int len;
        int sum;
        int head;
        int ptr;
        int lens[$];
        bit done;
        meta = args.pop_front();
        count = args.pop_front();
        sum = 0;
        head = 0;
        done = 1'b1;
        for (int i = 0; i < count; i++) begin
            len = args.pop_front();
            if (done) begin
                idle_gap();
                store_buffer(len, i == count - 1, meta, RDY_WAIT, done, ptr);
                if (!done) report_error("store_rdy stayed low during a frame");
                if (i == 0) head = ptr;
                lens.push_back(len);
                sum += len;
                if (done && i < count - 1 && frame_valid !== 1'b0) begin
                    report_error("frame_valid before end of frame");
                end
            end
        end
        if (done) begin
            check_frame_done(head, sum);
            frame_heads.push_back(head);
            frame_metas.push_back(meta);
            frame_counts.push_back(count);
            foreach (lens[i]) frame_lens.push_back(lens[i]);
        end
    endtask

    // Walk each stored frame through load_next
    task automatic gather_frames();
        int ptr;
        int meta;
        int count;
        int len;
        bit done;
        while (frame_heads.size() > 0) begin
            ptr = frame_heads.pop_front();
            meta = frame_metas.pop_front();
            count = frame_counts.pop_front();
            for (int i = 0; i < count; i++) begin
                len = frame_lens.pop_front();
                idle_gap();
                load_buffer(ptr, done);
                if (done) begin
                    if (load_len !== alloc_pkg::buf_len_t'(len)) begin
                        report_mismatch("load_len", load_len, len);
                    end
                    if (load_eof !== (i == count - 1)) begin
                        report_mismatch("load_eof", load_eof, i == count - 1);
                    end
                    if (i == 0 && load_meta !== alloc_pkg::meta_t'(meta)) begin
                        report_mismatch("load_meta", load_meta, meta);
                    end
                    ptr = load_next;
                end
            end
        end
    endtask

    task automatic run_stall();
        int expected;
        int len;
        int count;
        int ptr;
        int ptrs[$];
        bit done;
        expected = args.pop_front();
        len = args.pop_front();
        count = 0;
        done = 1'b1;
        // Back-to-back stores with end of frame on the expected last transfer
        while (done && count < alloc_pkg::NUM_BUFFERS) begin
            store_buffer(len, count + 1 == expected, 0, STALL_WAIT, done, ptr);
            if (done) begin
                ptrs.push_back(ptr);
                count++;
                if (count == expected) begin
                    check_frame_done(ptrs[0], count * len);
                    if (last_error !== (count * len > alloc_pkg::MAX_FRAME_SIZE)) begin
                        report_mismatch("frame_error", last_error,
                                        count * len > alloc_pkg::MAX_FRAME_SIZE);
                    end
                end
            end
        end
        if (count != expected) report_mismatch("store transfers before stall", count, expected);
        // One freed buffer reopens the store port
        foreach (ptrs[i]) begin
            recycle_buffer(ptrs[i]);
            if (i == 0 && store_rdy !== 1'b1) report_error("store_rdy still low after recycle");
        end
    endtask

    // -------------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------------
    initial begin
        int op;
        int limit_val;
        int exp_err;
        seed = 28965;
        rst = 1'b1;
        buffers = '0;
        store_req = 1'b0;
        store_len = '0;
        store_eof = 1'b0;
        store_meta = '0;
        load_req = 1'b0;
        load_ptr = '0;
        recycle_req = 1'b0;
        recycle_ptr = '0;
        errors = 0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        last_error = 1'b0;
        read_patterns();
        ops_ready = 1'b1;
        check_reset();
        end_test("reset");
        while (ops.size() > 0) begin
            op = ops.pop_front();
            case (op)
                "L": begin
                    limit_val = args.pop_front();
                    buffers = limit_val[alloc_pkg::PTR_WID:0];
                    // New limit reaches store_rdy in the next cycle
                    @(negedge clk);
                end
                "F": begin
                    run_frame();
                    end_test("frame store");
                end
                "E": begin
                    exp_err = args.pop_front();
                    if (last_error !== exp_err[0]) begin
                        report_mismatch("frame_error", last_error, exp_err);
                    end
                    end_test("frame error");
                end
                "G": begin
                    gather_frames();
                    end_test("gather");
                end
                default: begin
                    run_stall();
                    end_test("store stall");
                end
            endcase
        end
        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Budget per pattern op plus the reset test
    initial begin
        wait (ops_ready);
        repeat ((op_total + 1) * CYCLES_PER_OP) @(posedge clk);
        $display("Watchdog: run did not finish within %0d cycles", (op_total + 1) * CYCLES_PER_OP);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule : tb_alloc_sg_core

//--- alloc_sg_patterns.txt
# L limit | F meta(hex) count len... | E frame_error | G load all frames | S transfers len
# Limit 0 means all buffers, lengths and counts are decimal
L 0
F a5 3 64 20 1
E 0
F 3c 5 64 64 64 64 64
E 1
F 07 1 33
E 0
G
L 4
S 2 40
L 0
S 14 16
F 5e 4 64 64 64 64
E 0
F c1 5 64 64 64 64 1
E 1
G

//--- tb.f
alloc_pkg.sv
alloc_bv.sv
desc_ram.sv
alloc_scatter.sv
alloc_gather.sv
alloc_sg_core.sv
tb_alloc_sg_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_alloc_sg_core -f tb.f -o sim_alloc_sg \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_alloc_sg > sim.log 2>&1
cat sim.log

grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
